// File: game_pkg.sv
package game_pkg;

    // ====================
    // pixel colours
    // ====================

    typedef logic [2:0] rgb_t;  // one bit each for red, green and blue

    localparam rgb_t black_rgb      = 3'b000;
    localparam rgb_t background_rgb = 3'b001;
    localparam rgb_t meteor_rgb     = 3'b110;
    localparam rgb_t ship_rgb       = 3'b010;
    localparam rgb_t bullet_rgb     = 3'b111;
    localparam rgb_t won_rgb        = 3'b011;
    localparam rgb_t lost_rgb       = 3'b100;

    // ====================
    // sprites
    // ====================

    localparam int sprite_size = 16;  // edge of every square box in pixels

    typedef logic signed [2:0] velocity_t;  // pixels per motion strobe

    // ====================
    // game flow
    // ====================

    typedef enum logic [2:0]
    {
        st_idle,
        st_start,
        st_play,
        st_won,
        st_lost
    } game_state_t;

endpackage

// File: game_sprite_if.sv
`timescale 1ns/1ps

interface game_sprite_if
    import game_pkg::*;
#(
    parameter screen_width  = 640,
    parameter screen_height = 480
);

    localparam w_x = $clog2(screen_width);
    localparam w_y = $clog2(screen_height);

    logic [w_x - 1:0] write_x;
    logic [w_y - 1:0] write_y;
    velocity_t        write_dx;
    velocity_t        write_dy;

    logic             write_xy;       // single-cycle load of position and velocity
    logic             enable_update;  // motion runs while this level is high

    logic             within_screen;
    logic [w_x - 1:0] left;
    logic [w_x - 1:0] right;   // exclusive edge that reads zero while the sprite is hidden
    logic [w_y - 1:0] top;
    logic [w_y - 1:0] bottom;  // exclusive edge that reads zero while the sprite is hidden

    modport spawn  (output write_x, write_y, write_dx, write_dy);
    modport ctrl   (output write_xy, enable_update, input within_screen);
    modport sprite (input  write_x, write_y, write_dx, write_dy, write_xy, enable_update,
                    output within_screen, left, right, top, bottom);
    modport box    (input  left, right, top, bottom);

endinterface

// File: game_spawn.sv
`timescale 1ns/1ps

module game_spawn
    import game_pkg::*;
#(
    parameter screen_width  = 640,
    parameter screen_height = 480
)
(
    input                                    clk,
    input                                    rst_n,
    input        [1:0]                       left_right_keys,
    game_sprite_if.spawn                     meteor,
    game_sprite_if.spawn                     ship,
    game_sprite_if.spawn                     bullet,
    input        [$clog2(screen_width) - 1:0] ship_left
);

    localparam w_x = $clog2(screen_width);
    localparam w_y = $clog2(screen_height);

    localparam logic [w_x - 1:0] centre_x = w_x'(screen_width / 2 - sprite_size / 2);

    logic [15:0] lfsr;

    // steps every clock with the polynomial x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            lfsr <= 16'hace1;
        else
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end

    assign meteor.write_x  = centre_x + w_x'(lfsr[2:0]);  // small random jitter around centre
    assign meteor.write_y  = '0;
    assign meteor.write_dx = 3'sd0;
    assign meteor.write_dy = 3'sd1;

    assign ship.write_x    = centre_x;
    assign ship.write_y    = w_y'(screen_height - 20);
    assign ship.write_dy   = 3'sd0;

    always_comb
    begin
        case (left_right_keys)
            2'b10:   ship.write_dx = -3'sd1;
            2'b01:   ship.write_dx = 3'sd1;
            default: ship.write_dx = 3'sd0;  // both keys or none hold the ship still
        endcase
    end

    // the bullet leaves from the ship's muzzle, wherever the ship is now
    assign bullet.write_x  = ship_left;
    assign bullet.write_y  = w_y'(screen_height - 37);
    assign bullet.write_dx = 3'sd0;
    assign bullet.write_dy = -3'sd2;

    lfsr_never_zero: assert property (@(posedge clk) disable iff (!rst_n) lfsr != '0)
        else $error("lfsr locked up at zero");

endmodule

// File: game_sprite.sv
`timescale 1ns/1ps

module game_sprite
    import game_pkg::*;
#(
    parameter screen_width         = 640,
    parameter screen_height        = 480,
    parameter update_counter_width = 20
)
(
    input                 clk,
    input                 rst_n,
    game_sprite_if.sprite spr
);

    localparam w_x = $clog2(screen_width);
    localparam w_y = $clog2(screen_height);

    logic [w_x - 1:0]                  x;
    logic [w_y - 1:0]                  y;
    velocity_t                         dx;
    velocity_t                         dy;
    logic [update_counter_width - 1:0] update_cnt;
    logic                              strobe;
    logic                              visible;

    // ====================
    // motion
    // ====================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            update_cnt <= '0;
        else
            update_cnt <= update_cnt + 1'b1;
    end

    assign strobe = &update_cnt;  // one clock in every 2**update_counter_width

    always_ff @(posedge clk)
    begin
        if (spr.write_xy)
        begin
            x  <= spr.write_x;
            y  <= spr.write_y;
            dx <= spr.write_dx;
            dy <= spr.write_dy;
        end
        else if (spr.enable_update && strobe)
        begin
            x  <= x + w_x'(dx);  // wraps, which takes the sprite off screen
            y  <= y + w_y'(dy);
            // velocity follows the spawn side so the ship answers the keys
            dx <= spr.write_dx;
            dy <= spr.write_dy;
        end
    end

    // ====================
    // bounding box
    // ====================

    assign visible = spr.enable_update && (x < screen_width) && (y < screen_height);

    assign spr.within_screen = visible;

    // a hidden sprite has zero right and bottom edges, so it neither overlaps nor draws
    assign spr.left   = x;
    assign spr.top    = y;
    assign spr.right  = visible ? x + w_x'(sprite_size) : '0;
    assign spr.bottom = visible ? y + w_y'(sprite_size) : '0;

    write_xy_single: assert property (@(posedge clk) disable iff (!rst_n)
        spr.write_xy |=> !spr.write_xy)
        else $error("write_xy held for more than one cycle");

endmodule

// File: game_overlap.sv
`timescale 1ns/1ps

module game_overlap
#(
    parameter screen_width  = 640,
    parameter screen_height = 480
)
(
    input              clk,
    input              rst_n,
    game_sprite_if.box meteor,
    game_sprite_if.box ship,
    game_sprite_if.box bullet,
    output logic       hit,
    output logic       crash
);

    localparam w_x = $clog2(screen_width);
    localparam w_y = $clog2(screen_height);

    // edges are exclusive on the right and bottom so the compares are strict
    function automatic logic boxes_overlap(
        input logic [w_x - 1:0] l1,
        input logic [w_x - 1:0] r1,
        input logic [w_y - 1:0] t1,
        input logic [w_y - 1:0] b1,
        input logic [w_x - 1:0] l2,
        input logic [w_x - 1:0] r2,
        input logic [w_y - 1:0] t2,
        input logic [w_y - 1:0] b2
    );
        return (l1 < r2) && (l2 < r1) && (t1 < b2) && (t2 < b1);
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hit   <= 1'b0;
            crash <= 1'b0;
        end
        else
        begin
            hit   <= boxes_overlap(bullet.left, bullet.right, bullet.top, bullet.bottom,
                                   meteor.left, meteor.right, meteor.top, meteor.bottom);
            crash <= boxes_overlap(ship.left, ship.right, ship.top, ship.bottom,
                                   meteor.left, meteor.right, meteor.top, meteor.bottom);
        end
    end

endmodule

// File: game_master_fsm.sv
`timescale 1ns/1ps

module game_master_fsm
    import game_pkg::*;
#(
    parameter             update_counter_width = 20,
    parameter             game_time_width      = 25,
    parameter logic [3:0] win_score            = 4'd9
)
(
    input                clk,
    input                rst_n,
    input                launch_key,
    input                shoot,
    input                hit,
    input                crash,
    game_sprite_if.ctrl  meteor,
    game_sprite_if.ctrl  ship,
    game_sprite_if.ctrl  bullet,
    output game_state_t  state,
    output logic [3:0]   score
);

    localparam w_timer = update_counter_width + game_time_width;

    game_state_t        state_next;
    logic [w_timer - 1:0] timer;
    logic               timer_expired;
    logic               hit_d;
    logic               scored;
    logic               game_over;
    logic               bullet_on;

    // hit stays up for two cycles while the bullet is removed so only its first edge counts
    assign scored        = (state == st_play) && hit && !hit_d && !game_over;
    assign timer_expired = &timer;
    assign game_over     = crash || !meteor.within_screen || timer_expired;

    // ====================
    // state transitions
    // ====================

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle, st_won, st_lost:
                if (launch_key)
                    state_next = st_start;
            st_start:
                state_next = st_play;
            st_play:
                if (game_over)
                    state_next = st_lost;
                else if (scored && score + 4'd1 == win_score)
                    state_next = st_won;
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            score     <= '0;
            timer     <= '0;
            hit_d     <= 1'b0;
            bullet_on <= 1'b0;
        end
        else
        begin
            state <= state_next;
            hit_d <= hit;

            if (state == st_start)
                score <= '0;
            else if (scored)
                score <= score + 4'd1;

            if (state != st_play || scored)
                timer <= '0;  // every new meteor gets a full time slot
            else
                timer <= timer + 1'b1;

            if (state != st_play || scored)
                bullet_on <= 1'b0;
            else if (bullet.write_xy)
                bullet_on <= 1'b1;
        end
    end

    // ====================
    // sprite control
    // ====================

    assign meteor.write_xy      = (state == st_start) || scored;  // respawn on every hit
    assign ship.write_xy        = (state == st_start);
    assign bullet.write_xy      = (state == st_play) && shoot && !bullet.within_screen;

    assign meteor.enable_update = (state == st_play);
    assign ship.enable_update   = (state == st_play);
    assign bullet.enable_update = bullet_on;

    score_in_range: assert property (@(posedge clk) disable iff (!rst_n) score <= win_score)
        else $error("score went past win_score");

endmodule

// File: game_mixer.sv
`timescale 1ns/1ps

module game_mixer
    import game_pkg::*;
#(
    parameter screen_width  = 640,
    parameter screen_height = 480
)
(
    input                                      clk,
    input                                      rst_n,
    input                                      display_on,
    input        [$clog2(screen_width)  - 1:0] x,
    input        [$clog2(screen_height) - 1:0] y,
    game_sprite_if.box                         meteor,
    game_sprite_if.box                         ship,
    game_sprite_if.box                         bullet,
    input  game_state_t                        state,
    output rgb_t                               rgb
);

    localparam w_x = $clog2(screen_width);
    localparam w_y = $clog2(screen_height);

    rgb_t rgb_next;

    function automatic logic in_box(
        input logic [w_x - 1:0] px,
        input logic [w_y - 1:0] py,
        input logic [w_x - 1:0] left,
        input logic [w_x - 1:0] right,
        input logic [w_y - 1:0] top,
        input logic [w_y - 1:0] bottom
    );
        return (px >= left) && (px < right) && (py >= top) && (py < bottom);
    endfunction

    always_comb
    begin
        if (!display_on)
            rgb_next = black_rgb;
        else if (state == st_won)
            rgb_next = won_rgb;
        else if (state == st_lost)
            rgb_next = lost_rgb;
        else if (state == st_play &&
                 in_box(x, y, bullet.left, bullet.right, bullet.top, bullet.bottom))
            rgb_next = bullet_rgb;
        else if (state == st_play &&
                 in_box(x, y, ship.left, ship.right, ship.top, ship.bottom))
            rgb_next = ship_rgb;
        else if (state == st_play &&
                 in_box(x, y, meteor.left, meteor.right, meteor.top, meteor.bottom))
            rgb_next = meteor_rgb;
        else
            rgb_next = background_rgb;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rgb <= black_rgb;
        else
            rgb <= rgb_next;  // one pixel clock behind x and y
    end

endmodule

// File: game_top.sv
`timescale 1ns/1ps

module game_top
    import game_pkg::*;
#(
    parameter             screen_width         = 640,
    parameter             screen_height        = 480,
    parameter             update_counter_width = 20,
    parameter             game_time_width      = 25,
    parameter logic [3:0] win_score            = 4'd9
)
(
    input                                      clk,
    input                                      rst_n,
    input                                      launch_key,
    input        [1:0]                         left_right_keys,
    input                                      shoot,
    input                                      display_on,
    input        [$clog2(screen_width)  - 1:0] x,
    input        [$clog2(screen_height) - 1:0] y,
    output logic [3:0]                         score,
    output rgb_t                               rgb
);

    logic        hit;
    logic        crash;
    game_state_t state;

    game_sprite_if #(.screen_width(screen_width), .screen_height(screen_height)) meteor_if ();
    game_sprite_if #(.screen_width(screen_width), .screen_height(screen_height)) ship_if ();
    game_sprite_if #(.screen_width(screen_width), .screen_height(screen_height)) bullet_if ();

    // ====================
    // input side
    // ====================

    game_spawn #(.screen_width(screen_width), .screen_height(screen_height)) spawn
    (
        .clk             ( clk              ),
        .rst_n           ( rst_n            ),
        .left_right_keys ( left_right_keys  ),
        .meteor          ( meteor_if.spawn  ),
        .ship            ( ship_if.spawn    ),
        .bullet          ( bullet_if.spawn  ),
        .ship_left       ( ship_if.left     )
    );

    // ====================
    // sprites and game logic
    // ====================

    game_sprite #(screen_width, screen_height, update_counter_width) meteor_sprite
        (.clk(clk), .rst_n(rst_n), .spr(meteor_if.sprite));

    game_sprite #(screen_width, screen_height, update_counter_width) ship_sprite
        (.clk(clk), .rst_n(rst_n), .spr(ship_if.sprite));

    game_sprite #(screen_width, screen_height, update_counter_width) bullet_sprite
        (.clk(clk), .rst_n(rst_n), .spr(bullet_if.sprite));

    game_overlap #(.screen_width(screen_width), .screen_height(screen_height)) overlap
    (
        .clk    ( clk           ),
        .rst_n  ( rst_n         ),
        .meteor ( meteor_if.box ),
        .ship   ( ship_if.box   ),
        .bullet ( bullet_if.box ),
        .hit    ( hit           ),
        .crash  ( crash         )
    );

    game_master_fsm
    #(
        .update_counter_width ( update_counter_width ),
        .game_time_width      ( game_time_width      ),
        .win_score            ( win_score            )
    )
    master_fsm
    (
        .clk        ( clk            ),
        .rst_n      ( rst_n          ),
        .launch_key ( launch_key     ),
        .shoot      ( shoot          ),
        .hit        ( hit            ),
        .crash      ( crash          ),
        .meteor     ( meteor_if.ctrl ),
        .ship       ( ship_if.ctrl   ),
        .bullet     ( bullet_if.ctrl ),
        .state      ( state          ),
        .score      ( score          )
    );

    // ====================
    // output side
    // ====================

    game_mixer #(.screen_width(screen_width), .screen_height(screen_height)) mixer
    (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .display_on ( display_on    ),
        .x          ( x             ),
        .y          ( y             ),
        .meteor     ( meteor_if.box ),
        .ship       ( ship_if.box   ),
        .bullet     ( bullet_if.box ),
        .state      ( state         ),
        .rgb        ( rgb           )
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 3
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2.0) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles)
            @(posedge clk);
        #1 rst_n = 1'b1;  // released clear of the edge
    end

endmodule

// File: game_top_tb.sv
`timescale 1ns/1ps

module game_top_tb
    import game_pkg::*;
();

    localparam int         screen_width         = 640;
    localparam int         screen_height        = 480;
    localparam int         update_counter_width = 4;
    localparam int         game_time_width      = 8;
    localparam logic [3:0] win_score            = 4'd3;
    localparam int         clk_period           = 4;
    localparam int         num_tests            = 5;

    localparam int w_x           = $clog2(screen_width);
    localparam int w_y           = $clog2(screen_height);
    localparam int strobe_clocks = 2 ** update_counter_width;
    localparam int game_clocks   = strobe_clocks * 2 ** game_time_width;  // one full timer slot
    localparam int steer_strobes = 64;
    localparam int ship_x        = screen_width / 2 - sprite_size / 2;
    localparam int ship_y        = screen_height - 20;
    localparam int watchdog_ns   = num_tests * 2 * game_clocks * clk_period;

    logic             clk;
    logic             rst_n;
    logic             launch_key;
    logic [1:0]       left_right_keys;
    logic             shoot;
    logic             display_on;
    logic [w_x - 1:0] x;
    logic [w_y - 1:0] y;
    logic [3:0]       score;
    rgb_t             rgb;

    tb_clock_gen #(.period_ns(clk_period), .reset_cycles(3)) clock_gen
        (.clk(clk), .rst_n(rst_n));

    game_top
    #(
        .screen_width         ( screen_width         ),
        .screen_height        ( screen_height        ),
        .update_counter_width ( update_counter_width ),
        .game_time_width      ( game_time_width      ),
        .win_score            ( win_score            )
    )
    game_top_inst
    (
        .clk             ( clk             ),
        .rst_n           ( rst_n           ),
        .launch_key      ( launch_key      ),
        .left_right_keys ( left_right_keys ),
        .shoot           ( shoot           ),
        .display_on      ( display_on      ),
        .x               ( x               ),
        .y               ( y               ),
        .score           ( score           ),
        .rgb             ( rgb             )
    );

    // ====================
    // helpers
    // ====================

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // inputs change just after the edge
    endtask

    // rgb is registered, so the colour for x and y shows one edge later
    task automatic sample_pixel(input int px, input int py, output rgb_t colour);
        x = w_x'(px);
        y = w_y'(py);
        next_cycle();
        colour = rgb;
    endtask

    task automatic pulse_launch();
        launch_key = 1'b1;
        next_cycle();
        launch_key = 1'b0;
    endtask

    task automatic scan_row(input int py, input int x_first, input int x_last,
                            input rgb_t colour, output logic found);
        rgb_t seen;
        found = 1'b0;
        for (int px = x_first; px <= x_last; px++)
        begin
            sample_pixel(px, py, seen);
            if (seen === colour)
                found = 1'b1;
        end
    endtask

    task automatic wait_for_colour(input int px, input int py, input rgb_t colour,
                                   input int limit);
        rgb_t seen;
        int   cycles;
        cycles = 0;
        sample_pixel(px, py, seen);
        while (seen !== colour)
        begin
            cycles++;
            if (cycles > limit)
            begin
                $display("pixel (%0d, %0d) never turned to colour %0h", px, py, colour);
                stop_on_failure();
            end
            sample_pixel(px, py, seen);
        end
    endtask

    // ====================
    // tests
    // ====================

    task automatic test_reset_blanking();
        rgb_t seen;
        check_equal("score", 0, score);
        display_on = 1'b0;
        sample_pixel(0, 0, seen);
        check_equal("rgb", black_rgb, seen);
        sample_pixel(ship_x + 8, ship_y + 8, seen);
        check_equal("rgb", black_rgb, seen);
        sample_pixel(screen_width - 1, screen_height - 1, seen);
        check_equal("rgb", black_rgb, seen);
        display_on = 1'b1;
        sample_pixel(100, 200, seen);
        check_equal("rgb", background_rgb, seen);
    endtask

    task automatic test_launch_draws_ship();
        rgb_t seen;
        logic found;
        pulse_launch();
        repeat (3)
            next_cycle();
        sample_pixel(ship_x + 8, ship_y + 8, seen);
        check_equal("rgb at ship centre", ship_rgb, seen);
        // the meteor spawns up to 7 columns right of centre
        scan_row(4, ship_x, ship_x + sprite_size + 7, meteor_rgb, found);
        check_equal("meteor seen on row 4", 1, found);
    endtask

    task automatic test_steering();
        rgb_t seen;
        logic found;
        left_right_keys = 2'b10;
        repeat (steer_strobes * strobe_clocks)
            next_cycle();
        left_right_keys = 2'b00;
        repeat (2 * strobe_clocks)
            next_cycle();  // the held velocity applies at one more strobe
        sample_pixel(ship_x + 8, ship_y + 8, seen);
        check_equal("ship still at spawn", 0, seen == ship_rgb);
        scan_row(ship_y + 8, ship_x + 8 - steer_strobes - 4, ship_x + 8 - steer_strobes + 4,
                 ship_rgb, found);
        check_equal("ship seen after steering", 1, found);
        // the steered ship is out of the meteor's path so the round ends on the timer
        wait_for_colour(0, 0, lost_rgb, 2 * game_clocks);
    endtask

    task automatic test_hits_and_win();
        rgb_t       seen;
        logic [3:0] last_score;
        int         cycles;
        pulse_launch();
        repeat (2)
            next_cycle();
        check_equal("score", 0, score);
        last_score = score;
        cycles = 0;
        while (score != win_score)
        begin
            shoot = (cycles % 32 == 0);
            next_cycle();
            cycles++;
            if (score != last_score)
            begin
                check_equal("score", last_score + 1, score);
                last_score = score;
            end
            if (cycles > win_score * 2 * game_clocks)
            begin
                $display("score stuck at %0d, the game was not won", score);
                stop_on_failure();
            end
        end
        shoot = 1'b0;
        sample_pixel(0, 0, seen);
        check_equal("rgb", won_rgb, seen);
        sample_pixel(ship_x + 8, ship_y + 8, seen);
        check_equal("rgb", won_rgb, seen);
        sample_pixel(screen_width - 1, screen_height - 1, seen);
        check_equal("rgb", won_rgb, seen);
    endtask

    task automatic test_loss_restart();
        rgb_t seen;
        pulse_launch();
        repeat (2)
            next_cycle();
        check_equal("score", 0, score);
        wait_for_colour(ship_x + 8, ship_y + 8, lost_rgb, 2 * game_clocks);
        check_equal("score", 0, score);  // no shots were fired in this round
        sample_pixel(0, 0, seen);
        check_equal("rgb", lost_rgb, seen);
        sample_pixel(screen_width - 1, screen_height - 1, seen);
        check_equal("rgb", lost_rgb, seen);
        repeat (strobe_clocks)
            next_cycle();
        check_equal("score", 0, score);
        pulse_launch();
        repeat (2)
            next_cycle();
        check_equal("score", 0, score);
        sample_pixel(10, 10, seen);
        check_equal("rgb", background_rgb, seen);
    endtask

    // ====================
    // run
    // ====================

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        stop_on_failure();
    end

    initial
    begin
        launch_key      = 1'b0;
        left_right_keys = 2'b00;
        shoot           = 1'b0;
        display_on      = 1'b0;
        x               = '0;
        y               = '0;
        wait (rst_n === 1'b1);
        next_cycle();
        test_reset_blanking();
        test_launch_draws_ship();
        test_steering();
        test_hits_and_win();
        test_loss_restart();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: game.f
game_pkg.sv
game_sprite_if.sv
game_spawn.sv
game_sprite.sv
game_overlap.sv
game_master_fsm.sv
game_mixer.sv
game_top.sv
tb_clock_gen.sv
game_top_tb.sv
